// File: flist.f
hdl/dram_pkg.sv
hdl/axi_spill_reg.sv
hdl/axi_cut.sv
hdl/id_narrower.sv
hdl/dram_ctrl_model.sv
hdl/dram_wrapper.sv
bench/tb_dram_wrapper.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the dram_wrapper testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_dram_wrapper \
  -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "Simulation exited with an error, see sim.log"
  exit 1
fi
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: bench/tb_dram_wrapper.sv
/*
 * Directed testbench for dram_wrapper. Single-beat transfers only.
 * One write and one read are in flight at a time, as the ID narrower allows.
 * The reference memory aliases every 4 KiB like the controller.
 */
`timescale 1ns/1ps

module tb_dram_wrapper import dram_pkg::*; ();

  localparam int unsigned TimeoutCycles = 100;
  localparam int unsigned HoldCycles    = 20;
  localparam int unsigned RefWords      = 2 ** (DramAddrWidth - 3);
  localparam int unsigned ShowWidth     = 128;

  logic                 clk;
  logic                 rst_n;
  logic                 dram_clk;
  axi_req_t             soc_req;
  axi_rsp_t             soc_rsp;
  logic [DataWidth-1:0] ref_mem [RefWords];
  logic [31:0]          rand_state;
  int unsigned          err_count;
  int unsigned          pass_tests;
  int unsigned          fail_tests;

  dram_wrapper dram_wrapper_i (
    .soc_clk_i  (clk),
    .rst_n_i    (rst_n),
    .soc_req_i  (soc_req),
    .soc_rsp_o  (soc_rsp),
    .dram_clk_o (dram_clk)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic logic [DataWidth-1:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi, lo};
  endfunction

  task automatic report_mismatch(input string test, input string what,
                                 input logic [ShowWidth-1:0] expected,
                                 input logic [ShowWidth-1:0] actual);
    $display("MISMATCH %s %s: expected %0h, actual %0h", test, what, expected, actual);
    err_count++;
  endtask

  task automatic report_timeout(input string test, input string what);
    $display("%s: timed out waiting for %s", test, what);
    err_count++;
  endtask

  // Reference memory update under byte strobes
  task automatic ref_write(input logic [AddrWidth-1:0] addr,
                           input logic [DataWidth-1:0] data,
                           input logic [StrbWidth-1:0] strb);
    for (int unsigned i = 0; i < StrbWidth; i++) begin
      if (strb[i]) ref_mem[addr[DramAddrWidth-1:3]][i*8 +: 8] = data[i*8 +: 8];
    end
  endtask

  task automatic finish_test(input string name, input int unsigned errs_before);
    if (err_count == errs_before) begin
      pass_tests++;
      $display("%s: passed", name);
    end else begin
      fail_tests++;
      $display("%s: failed with %0d errors", name, err_count - errs_before);
    end
  endtask

  ////////////////////////////////////////
  // AXI drivers
  ////////////////////////////////////////

  // AW and W may complete in different cycles
  task automatic send_write(input string test, input logic [AddrWidth-1:0] addr,
                            input logic [SocIdWidth-1:0] id,
                            input logic [DataWidth-1:0] data,
                            input logic [StrbWidth-1:0] strb);
    logic        aw_hs;
    logic        w_hs;
    logic        aw_done;
    logic        w_done;
    int unsigned cycles;
    soc_req.aw.id    = id;
    soc_req.aw.addr  = addr;
    soc_req.aw_valid = 1'b1;
    soc_req.w.data   = data;
    soc_req.w.strb   = strb;
    soc_req.w.last   = 1'b1;
    soc_req.w_valid  = 1'b1;
    aw_done = 1'b0;
    w_done  = 1'b0;
    cycles  = 0;
    while (!(aw_done && w_done) && cycles < TimeoutCycles) begin
      @(negedge clk);
      aw_hs = soc_req.aw_valid & soc_rsp.aw_ready;
      w_hs  = soc_req.w_valid & soc_rsp.w_ready;
      @(posedge clk);
      #1;
      if (aw_hs) begin
        soc_req.aw_valid = 1'b0;
        aw_done          = 1'b1;
      end
      if (w_hs) begin
        soc_req.w_valid = 1'b0;
        w_done          = 1'b1;
      end
      cycles++;
    end
    if (!(aw_done && w_done)) begin
      report_timeout(test, "the AW and W handshakes");
      soc_req.aw_valid = 1'b0;
      soc_req.w_valid  = 1'b0;
    end
  endtask

  task automatic send_read(input string test, input logic [AddrWidth-1:0] addr,
                           input logic [SocIdWidth-1:0] id);
    logic        ar_hs;
    int unsigned cycles;
    soc_req.ar.id    = id;
    soc_req.ar.addr  = addr;
    soc_req.ar_valid = 1'b1;
    ar_hs  = 1'b0;
    cycles = 0;
    while (!ar_hs && cycles < TimeoutCycles) begin
      @(negedge clk);
      ar_hs = soc_req.ar_valid & soc_rsp.ar_ready;
      @(posedge clk);
      #1;
      cycles++;
    end
    soc_req.ar_valid = 1'b0;
    if (!ar_hs) report_timeout(test, "the AR handshake");
  endtask

  task automatic wait_b(input string test, input logic [SocIdWidth-1:0] exp_id);
    logic        seen;
    int unsigned cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < TimeoutCycles) begin
      @(negedge clk);
      if (soc_rsp.b_valid && soc_req.b_ready) begin
        seen = 1'b1;
        if (soc_rsp.b.id !== exp_id)
          report_mismatch(test, "b.id", ShowWidth'(exp_id), ShowWidth'(soc_rsp.b.id));
        if (soc_rsp.b.resp !== RespOkay)
          report_mismatch(test, "b.resp", ShowWidth'(RespOkay), ShowWidth'(soc_rsp.b.resp));
      end
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!seen) report_timeout(test, "the B response");
  endtask

  task automatic wait_r(input string test, input logic [SocIdWidth-1:0] exp_id,
                        input logic [DataWidth-1:0] exp_data);
    logic        seen;
    int unsigned cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < TimeoutCycles) begin
      @(negedge clk);
      if (soc_rsp.r_valid && soc_req.r_ready) begin
        seen = 1'b1;
        if (soc_rsp.r.id !== exp_id)
          report_mismatch(test, "r.id", ShowWidth'(exp_id), ShowWidth'(soc_rsp.r.id));
        if (soc_rsp.r.data !== exp_data)
          report_mismatch(test, "r.data", ShowWidth'(exp_data), ShowWidth'(soc_rsp.r.data));
        if (soc_rsp.r.resp !== RespOkay)
          report_mismatch(test, "r.resp", ShowWidth'(RespOkay), ShowWidth'(soc_rsp.r.resp));
        if (soc_rsp.r.last !== 1'b1)
          report_mismatch(test, "r.last", ShowWidth'(1'b1), ShowWidth'(soc_rsp.r.last));
      end
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!seen) report_timeout(test, "the R response");
  endtask

  task automatic axi_write(input string test, input logic [AddrWidth-1:0] addr,
                           input logic [SocIdWidth-1:0] id,
                           input logic [DataWidth-1:0] data,
                           input logic [StrbWidth-1:0] strb);
    send_write(test, addr, id, data, strb);
    ref_write(addr, data, strb);
    wait_b(test, id);
  endtask

  task automatic axi_read(input string test, input logic [AddrWidth-1:0] addr,
                          input logic [SocIdWidth-1:0] id);
    send_read(test, addr, id);
    wait_r(test, id, ref_mem[addr[DramAddrWidth-1:3]]);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  // DRAM clock output follows the SoC clock in both phases
  task automatic test_reset();
    int unsigned errs;
    errs = err_count;
    repeat (10) begin
      @(negedge clk);
      if (soc_rsp.b_valid !== 1'b0)
        report_mismatch("reset", "b_valid", ShowWidth'(1'b0), ShowWidth'(soc_rsp.b_valid));
      if (soc_rsp.r_valid !== 1'b0)
        report_mismatch("reset", "r_valid", ShowWidth'(1'b0), ShowWidth'(soc_rsp.r_valid));
      #1;
      if (dram_clk !== 1'b0)
        report_mismatch("reset", "dram_clk low", ShowWidth'(1'b0), ShowWidth'(dram_clk));
      @(posedge clk);
      #1;
      if (dram_clk !== 1'b1)
        report_mismatch("reset", "dram_clk high", ShowWidth'(1'b1), ShowWidth'(dram_clk));
    end
    finish_test("reset", errs);
  endtask

  task automatic test_write_read();
    int unsigned errs;
    errs = err_count;
    for (int unsigned i = 0; i < 16; i++) begin
      axi_write("write_read", 32'h1000_0200 + i * 8, SocIdWidth'(i), rand_word(), '1);
    end
    for (int unsigned i = 0; i < 16; i++) begin
      axi_read("write_read", 32'h1000_0200 + i * 8, SocIdWidth'(i));
    end
    finish_test("write_read", errs);
  endtask

  task automatic test_strobes();
    int unsigned errs;
    errs = err_count;
    axi_write("strobes", 32'h0000_0840, 6'h01, rand_word(), 8'hff);
    axi_write("strobes", 32'h0000_0840, 6'h02, rand_word(), 8'ha5);
    axi_read("strobes", 32'h0000_0840, 6'h03);
    finish_test("strobes", errs);
  endtask

  // Upper ID bits exist only on the SoC side
  task automatic test_ids();
    logic [SocIdWidth-1:0] ids [4];
    int unsigned           errs;
    errs = err_count;
    ids  = '{6'h3f, 6'h35, 6'h2a, 6'h11};
    for (int unsigned i = 0; i < 4; i++) begin
      axi_write("ids", 32'h0000_0900 + i * 8, ids[i], rand_word(), '1);
      axi_read("ids", 32'h0000_0900 + i * 8, ids[i]);
    end
    finish_test("ids", errs);
  endtask

  task automatic test_alias();
    int unsigned errs;
    errs = err_count;
    axi_write("alias", 32'h0000_0a18, 6'h04, rand_word(), '1);
    axi_write("alias", 32'h0000_0a18 + 32'd4096, 6'h05, rand_word(), '1);
    axi_read("alias", 32'h0000_0a18, 6'h06);
    finish_test("alias", errs);
  endtask

  task automatic test_backpressure();
    b_chan_t               b_first;
    r_chan_t               r_first;
    logic                  both;
    int unsigned           cycles;
    int unsigned           errs;
    logic [DataWidth-1:0]  wdata;
    errs = err_count;
    axi_write("backpressure", 32'h0000_0c08, 6'h07, rand_word(), '1);
    soc_req.b_ready = 1'b0;
    soc_req.r_ready = 1'b0;
    wdata = rand_word();
    send_write("backpressure", 32'h0000_0c00, 6'h2b, wdata, '1);
    ref_write(32'h0000_0c00, wdata, '1);
    send_read("backpressure", 32'h0000_0c08, 6'h1c);
    both   = 1'b0;
    cycles = 0;
    while (!both && cycles < TimeoutCycles) begin
      @(negedge clk);
      both    = soc_rsp.b_valid & soc_rsp.r_valid;
      b_first = soc_rsp.b;
      r_first = soc_rsp.r;
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!both) report_timeout("backpressure", "both held responses");
    // Responses must not move while ready is low
    for (int unsigned i = 0; i < HoldCycles; i++) begin
      @(negedge clk);
      if (!soc_rsp.b_valid || !soc_rsp.r_valid) begin
        $display("backpressure: a response valid dropped while ready was low");
        err_count++;
      end
      if (soc_rsp.b !== b_first)
        report_mismatch("backpressure", "held b", ShowWidth'(b_first), ShowWidth'(soc_rsp.b));
      if (soc_rsp.r !== r_first)
        report_mismatch("backpressure", "held r", ShowWidth'(r_first), ShowWidth'(soc_rsp.r));
      @(posedge clk);
      #1;
    end
    soc_req.b_ready = 1'b1;
    wait_b("backpressure", 6'h2b);
    soc_req.r_ready = 1'b1;
    wait_r("backpressure", 6'h1c, ref_mem[9'(32'h0000_0c08 >> 3)]);
    axi_read("backpressure", 32'h0000_0c00, 6'h08);
    finish_test("backpressure", errs);
  endtask

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////

  initial begin
    rand_state      = 32'd8378;
    err_count       = 0;
    pass_tests      = 0;
    fail_tests      = 0;
    soc_req         = '0;
    soc_req.b_ready = 1'b1;
    soc_req.r_ready = 1'b1;
    rst_n           = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset();
    test_write_read();
    test_strobes();
    test_ids();
    test_alias();
    test_backpressure();
    $display("Tests passed: %0d, failed: %0d", pass_tests, fail_tests);
    if (err_count == 0 && fail_tests == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: hdl/dram_wrapper.sv
/*
 * DRAM-side AXI subsystem: register cut, ID narrower, controller model.
 * Single clock domain, so dram_clk_o is the SoC clock itself.
 * Single-beat transfers only.
 */
`timescale 1ns/1ps

module dram_wrapper import dram_pkg::*; (
  input  logic     soc_clk_i,
  input  logic     rst_n_i,
  input  axi_req_t soc_req_i,
  output axi_rsp_t soc_rsp_o,
  output logic     dram_clk_o
);

  // Cut output toward the narrower
  axi_req_t cut_req;
  axi_rsp_t cut_rsp;
  // Narrower output toward the controller
  axi_req_t nar_req;
  axi_rsp_t nar_rsp;

  // No crossing here
  assign dram_clk_o = soc_clk_i;

  ////////////////////////////////////////
  // Register cut
  ////////////////////////////////////////

  axi_cut i_axi_cut (
    .soc_clk_i (soc_clk_i),
    .rst_n_i   (rst_n_i),
    .slv_req_i (soc_req_i),
    .slv_rsp_o (soc_rsp_o),
    .mst_req_o (cut_req),
    .mst_rsp_i (cut_rsp)
  );

  ////////////////////////////////////////
  // ID narrowing
  ////////////////////////////////////////

  id_narrower i_id_narrower (
    .soc_clk_i (soc_clk_i),
    .rst_n_i   (rst_n_i),
    .slv_req_i (cut_req),
    .slv_rsp_o (cut_rsp),
    .mst_req_o (nar_req),
    .mst_rsp_i (nar_rsp)
  );

  // Controller model
  dram_ctrl_model i_dram (
    .soc_clk_i (soc_clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (nar_req),
    .rsp_o     (nar_rsp)
  );

endmodule

// File: hdl/dram_ctrl_model.sv
/*
 * Behavioural DRAM controller, a stand-in for the vendor memory IP.
 * Addresses above DramAddrWidth are ignored. Responses come DramLatency cycles
 * after acceptance and are always OKAY. Memory contents are not reset.
 */
`timescale 1ns/1ps

module dram_ctrl_model import dram_pkg::*; (
  input  logic     soc_clk_i,
  input  logic     rst_n_i,
  input  axi_req_t req_i,
  output axi_rsp_t rsp_o
);

  logic [DataWidth-1:0]    mem_q [MemWords];
  logic                    wr_busy_q;
  logic                    rd_busy_q;
  logic [LatCntWidth-1:0]  wr_cnt_q;
  logic [LatCntWidth-1:0]  rd_cnt_q;
  logic [SocIdWidth-1:0]   wr_id_q;
  logic [SocIdWidth-1:0]   rd_id_q;
  logic [WordIdxWidth-1:0] rd_idx_q;
  logic [DataWidth-1:0]    rd_data_q;
  logic [WordIdxWidth-1:0] wr_idx;
  logic                    wr_acc;
  logic                    rd_acc;
  logic                    b_done;
  logic                    r_done;

  assign wr_idx = req_i.aw.addr[DramAddrWidth-1:ByteOffWidth];

  // AW and W are taken together, busy covers service and held response
  assign wr_acc = req_i.aw_valid & req_i.w_valid & ~wr_busy_q;
  assign rd_acc = req_i.ar_valid & ~rd_busy_q;
  assign b_done = rsp_o.b_valid & req_i.b_ready;
  assign r_done = rsp_o.r_valid & req_i.r_ready;

  always_comb begin
    rsp_o          = '0;
    rsp_o.aw_ready = ~wr_busy_q & req_i.w_valid;
    rsp_o.w_ready  = ~wr_busy_q & req_i.aw_valid;
    rsp_o.ar_ready = ~rd_busy_q;
    rsp_o.b_valid  = wr_busy_q & (wr_cnt_q == '0);
    rsp_o.b.id     = wr_id_q;
    rsp_o.b.resp   = RespOkay;
    rsp_o.r_valid  = rd_busy_q & (rd_cnt_q == '0);
    rsp_o.r.id     = rd_id_q;
    rsp_o.r.data   = rd_data_q;
    rsp_o.r.resp   = RespOkay;
    rsp_o.r.last   = 1'b1;
  end

  ////////////////////////////////////////
  // Latency countdown per direction
  ////////////////////////////////////////

  always_ff @(posedge soc_clk_i) begin
    if (!rst_n_i) begin
      wr_busy_q <= 1'b0;
      wr_cnt_q  <= '0;
      rd_busy_q <= 1'b0;
      rd_cnt_q  <= '0;
    end else begin
      if (wr_acc) begin
        wr_busy_q <= 1'b1;
        wr_cnt_q  <= LatCntWidth'(DramLatency);
      end else if (b_done) begin
        wr_busy_q <= 1'b0;
      end else if (wr_cnt_q != '0) begin
        wr_cnt_q <= wr_cnt_q - 1'b1;
      end
      if (rd_acc) begin
        rd_busy_q <= 1'b1;
        rd_cnt_q  <= LatCntWidth'(DramLatency);
      end else if (r_done) begin
        rd_busy_q <= 1'b0;
      end else if (rd_cnt_q != '0) begin
        rd_cnt_q <= rd_cnt_q - 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  always_ff @(posedge soc_clk_i) begin
    if (wr_acc) begin
      wr_id_q <= req_i.aw.id;
      for (int unsigned i = 0; i < StrbWidth; i++) begin
        if (req_i.w.strb[i]) mem_q[wr_idx][i*8 +: 8] <= req_i.w.data[i*8 +: 8];
      end
    end
    if (rd_acc) begin
      rd_id_q  <= req_i.ar.id;
      rd_idx_q <= req_i.ar.addr[DramAddrWidth-1:ByteOffWidth];
    end
    // Sample on the last service cycle so r data stays stable while held
    if (rd_busy_q && rd_cnt_q == LatCntWidth'(1)) rd_data_q <= mem_q[rd_idx_q];
  end

endmodule

// File: hdl/id_narrower.sv
/*
 * Narrows AW/AR IDs to DramIdWidth bits and restores the full ID on B/R.
 * At most one write and one read may be outstanding, which keeps the saved ID
 * matched to the returning response. Forward path is combinational.
 */
`timescale 1ns/1ps

module id_narrower import dram_pkg::*; (
  input  logic     soc_clk_i,
  input  logic     rst_n_i,
  input  axi_req_t slv_req_i,
  output axi_rsp_t slv_rsp_o,
  output axi_req_t mst_req_o,
  input  axi_rsp_t mst_rsp_i
);

  logic                  aw_pend_q;
  logic                  ar_pend_q;
  logic [SocIdWidth-1:0] aw_id_q;
  logic [SocIdWidth-1:0] ar_id_q;
  logic                  aw_hs;
  logic                  ar_hs;
  logic                  b_hs;
  logic                  r_hs;

  // Low ID bits go downstream, upper bits forced to zero
  always_comb begin
    mst_req_o                            = slv_req_i;
    mst_req_o.aw.id                      = '0;
    mst_req_o.aw.id[DramIdWidth-1:0]     = slv_req_i.aw.id[DramIdWidth-1:0];
    mst_req_o.ar.id                      = '0;
    mst_req_o.ar.id[DramIdWidth-1:0]     = slv_req_i.ar.id[DramIdWidth-1:0];
    mst_req_o.aw_valid                   = slv_req_i.aw_valid & ~aw_pend_q;
    mst_req_o.ar_valid                   = slv_req_i.ar_valid & ~ar_pend_q;
  end

  always_comb begin
    slv_rsp_o          = mst_rsp_i;
    slv_rsp_o.b.id     = aw_id_q;
    slv_rsp_o.r.id     = ar_id_q;
    slv_rsp_o.aw_ready = mst_rsp_i.aw_ready & ~aw_pend_q;
    slv_rsp_o.ar_ready = mst_rsp_i.ar_ready & ~ar_pend_q;
  end

  assign aw_hs = slv_req_i.aw_valid & slv_rsp_o.aw_ready;
  assign ar_hs = slv_req_i.ar_valid & slv_rsp_o.ar_ready;
  assign b_hs  = mst_rsp_i.b_valid & slv_req_i.b_ready;
  assign r_hs  = mst_rsp_i.r_valid & slv_req_i.r_ready;

  // Pending flags, held from request handshake to response handshake
  always_ff @(posedge soc_clk_i) begin
    if (!rst_n_i) begin
      aw_pend_q <= 1'b0;
      ar_pend_q <= 1'b0;
    end else begin
      if (aw_hs) aw_pend_q <= 1'b1;
      else if (b_hs) aw_pend_q <= 1'b0;
      if (ar_hs) ar_pend_q <= 1'b1;
      else if (r_hs) ar_pend_q <= 1'b0;
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (aw_hs) aw_id_q <= slv_req_i.aw.id;
    if (ar_hs) ar_id_q <= slv_req_i.ar.id;
  end

endmodule

// File: hdl/axi_cut.sv
/*
 * Register cut on all five AXI channels.
 * Breaks every combinational path between the slave and master ports.
 */
`timescale 1ns/1ps

module axi_cut import dram_pkg::*; (
  input  logic     soc_clk_i,
  input  logic     rst_n_i,
  input  axi_req_t slv_req_i,
  output axi_rsp_t slv_rsp_o,
  output axi_req_t mst_req_o,
  input  axi_rsp_t mst_rsp_i
);

  ////////////////////////////////////////
  // Request channels
  ////////////////////////////////////////

  axi_spill_reg #(.payload_t(aw_chan_t)) i_spill_aw (
    .clk_i   (soc_clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (slv_req_i.aw_valid),
    .ready_o (slv_rsp_o.aw_ready),
    .data_i  (slv_req_i.aw),
    .valid_o (mst_req_o.aw_valid),
    .ready_i (mst_rsp_i.aw_ready),
    .data_o  (mst_req_o.aw)
  );

  axi_spill_reg #(.payload_t(w_chan_t)) i_spill_w (
    .clk_i   (soc_clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (slv_req_i.w_valid),
    .ready_o (slv_rsp_o.w_ready),
    .data_i  (slv_req_i.w),
    .valid_o (mst_req_o.w_valid),
    .ready_i (mst_rsp_i.w_ready),
    .data_o  (mst_req_o.w)
  );

  axi_spill_reg #(.payload_t(ar_chan_t)) i_spill_ar (
    .clk_i   (soc_clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (slv_req_i.ar_valid),
    .ready_o (slv_rsp_o.ar_ready),
    .data_i  (slv_req_i.ar),
    .valid_o (mst_req_o.ar_valid),
    .ready_i (mst_rsp_i.ar_ready),
    .data_o  (mst_req_o.ar)
  );

  ////////////////////////////////////////
  // Response channels
  ////////////////////////////////////////

  axi_spill_reg #(.payload_t(b_chan_t)) i_spill_b (
    .clk_i   (soc_clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (mst_rsp_i.b_valid),
    .ready_o (mst_req_o.b_ready),
    .data_i  (mst_rsp_i.b),
    .valid_o (slv_rsp_o.b_valid),
    .ready_i (slv_req_i.b_ready),
    .data_o  (slv_rsp_o.b)
  );

  axi_spill_reg #(.payload_t(r_chan_t)) i_spill_r (
    .clk_i   (soc_clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (mst_rsp_i.r_valid),
    .ready_o (mst_req_o.r_ready),
    .data_i  (mst_rsp_i.r),
    .valid_o (slv_rsp_o.r_valid),
    .ready_i (slv_req_i.r_ready),
    .data_o  (slv_rsp_o.r)
  );

endmodule

// File: hdl/axi_spill_reg.sv
/*
 * Two-entry spill register for one valid/ready channel.
 * Output valid follows an input handshake by one cycle, with full throughput.
 * Payload registers have no reset, only the fill flags do.
 */
`timescale 1ns/1ps

module axi_spill_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  payload_t a_data_q;
  payload_t b_data_q;
  logic     a_full_q;
  logic     b_full_q;
  logic     a_fill;
  logic     a_drain;
  logic     b_fill;
  logic     b_drain;

  // Slot A takes new data, slot B holds the older entry under back-pressure
  assign a_fill  = valid_i & ready_o;
  assign a_drain = a_full_q & ~b_full_q;
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) a_full_q <= a_fill;
      if (b_fill || b_drain) b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= data_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  // B is always older than A when both are full
  assign ready_o = ~a_full_q | ~b_full_q;
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

// File: hdl/dram_pkg.sv
/*
 * Widths, latency and AXI channel types shared by the DRAM subsystem.
 * Only single-beat transfers exist, so no len, size or burst fields are carried.
 * The SoC and the DRAM sides use the same data width.
 */
package dram_pkg;

  ////////////////////////////////////////
  // Widths and timing
  ////////////////////////////////////////

  localparam int unsigned SocIdWidth    = 6;
  localparam int unsigned DramIdWidth   = 4;
  localparam int unsigned AddrWidth     = 32;
  // Controller decodes only these byte address bits, so it aliases every 4 KiB
  localparam int unsigned DramAddrWidth = 12;
  localparam int unsigned DataWidth     = 64;
  localparam int unsigned StrbWidth     = DataWidth / 8;
  localparam int unsigned ByteOffWidth  = $clog2(StrbWidth);
  localparam int unsigned WordIdxWidth  = DramAddrWidth - ByteOffWidth;
  localparam int unsigned MemWords      = 2 ** WordIdxWidth;
  localparam int unsigned DramLatency   = 4;
  localparam int unsigned LatCntWidth   = $clog2(DramLatency + 1);

  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlverr = 2'b10;

  ////////////////////////////////////////
  // AXI channels
  ////////////////////////////////////////

  typedef struct packed {
    logic [SocIdWidth-1:0] id;
    logic [AddrWidth-1:0]  addr;
  } aw_chan_t;

  typedef struct packed {
    logic [SocIdWidth-1:0] id;
    logic [AddrWidth-1:0]  addr;
  } ar_chan_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strb;
    logic                 last;
  } w_chan_t;

  typedef struct packed {
    logic [SocIdWidth-1:0] id;
    logic [1:0]            resp;
  } b_chan_t;

  typedef struct packed {
    logic [SocIdWidth-1:0] id;
    logic [DataWidth-1:0]  data;
    logic [1:0]            resp;
    logic                  last;
  } r_chan_t;

  // Requester to responder
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    ar_chan_t ar;
    logic     ar_valid;
    logic     b_ready;
    logic     r_ready;
  } axi_req_t;

  // Responder to requester
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    logic    ar_ready;
    b_chan_t b;
    logic    b_valid;
    r_chan_t r;
    logic    r_valid;
  } axi_rsp_t;

endpackage
